// File: src/core_pkg.sv
package core_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  rf_wen_t;

    // one entry per supported operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // funct codes under SPECIAL, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // boot vector of the kseg1 rom
    localparam word_t DEFAULT_RESET_PC = 32'hbfc0_0000;

    // full-word write on the trace port
    localparam rf_wen_t RF_WEN_ALL = 4'hf;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_pkg::word_t RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
    input  logic            aclk,
    input  logic            rst,
    input  logic            inst_valid,
    input  core_pkg::word_t inst,
    output logic            fs_valid,
    output core_pkg::word_t fs_pc,
    output core_pkg::word_t fs_inst
);

    // pc handed to the next accepted instruction
    core_pkg::word_t next_pc;

    always_ff @(posedge aclk) begin
        if (rst) begin
            next_pc  <= RESET_PC;
            fs_valid <= 1'b0;
        end else begin
            fs_valid <= inst_valid;
            if (inst_valid) begin
                next_pc <= next_pc + 32'd4;
            end
        end
    end

    // fetch register, loaded only on a strobe
    always_ff @(posedge aclk) begin
        if (inst_valid) begin
            fs_pc   <= next_pc;
            fs_inst <= inst;
        end
    end

    // pc stays word aligned for any aligned RESET_PC
    pc_aligned_a: assert property (@(posedge aclk) disable iff (rst)
        fs_valid |-> fs_pc[1:0] == 2'b00);

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                aclk,
    input  logic                rst,
    input  logic                fs_valid,
    input  core_pkg::word_t     fs_pc,
    input  core_pkg::word_t     fs_inst,
    input  logic                es_fwd_wen,
    input  core_pkg::word_t     es_result,
    input  logic                rf_we,
    input  core_pkg::reg_addr_t rf_waddr,
    input  core_pkg::word_t     rf_wdata,
    output logic                es_valid,
    output core_pkg::word_t     es_pc,
    output core_pkg::alu_op_t   es_op,
    output core_pkg::word_t     es_src_a,
    output core_pkg::word_t     es_src_b,
    output logic [4:0]          es_shamt,
    output core_pkg::reg_addr_t es_dest,
    output logic                es_wen
);

    // instruction fields
    logic [5:0]          opcode;
    logic [5:0]          funct;
    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::reg_addr_t rd;
    logic [4:0]          shamt;
    logic [15:0]         imm;

    // decoded controls
    core_pkg::alu_op_t   ds_op;
    logic                ds_known;
    logic                ds_is_imm;
    logic                ds_sign_ext;
    core_pkg::reg_addr_t ds_dest_raw;
    core_pkg::reg_addr_t ds_dest;
    logic                ds_wen;
    core_pkg::word_t     ds_imm_ext;
    core_pkg::word_t     ds_rs_val;
    core_pkg::word_t     ds_rt_val;
    core_pkg::word_t     ds_src_b;

    core_pkg::word_t     rf [32];

    assign opcode = fs_inst[31:26];
    assign rs     = fs_inst[25:21];
    assign rt     = fs_inst[20:16];
    assign rd     = fs_inst[15:11];
    assign shamt  = fs_inst[10:6];
    assign funct  = fs_inst[5:0];
    assign imm    = fs_inst[15:0];

    always_comb begin
        ds_op       = core_pkg::ALU_ADD;
        ds_known    = 1'b1;
        ds_is_imm   = 1'b0;
        ds_sign_ext = 1'b0;
        case (opcode)
            core_pkg::OPC_SPECIAL: begin
                case (funct)
                    core_pkg::FN_ADDU: ds_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUBU: ds_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  ds_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   ds_op = core_pkg::ALU_OR;
                    core_pkg::FN_XOR:  ds_op = core_pkg::ALU_XOR;
                    core_pkg::FN_NOR:  ds_op = core_pkg::ALU_NOR;
                    core_pkg::FN_SLT:  ds_op = core_pkg::ALU_SLT;
                    core_pkg::FN_SLTU: ds_op = core_pkg::ALU_SLTU;
                    core_pkg::FN_SLL:  ds_op = core_pkg::ALU_SLL;
                    core_pkg::FN_SRL:  ds_op = core_pkg::ALU_SRL;
                    core_pkg::FN_SRA:  ds_op = core_pkg::ALU_SRA;
                    default:           ds_known = 1'b0;
                endcase
            end
            core_pkg::OPC_ADDIU: begin
                ds_is_imm   = 1'b1;
                ds_sign_ext = 1'b1;
            end
            core_pkg::OPC_ANDI: begin
                ds_op     = core_pkg::ALU_AND;
                ds_is_imm = 1'b1;
            end
            core_pkg::OPC_ORI: begin
                ds_op     = core_pkg::ALU_OR;
                ds_is_imm = 1'b1;
            end
            core_pkg::OPC_XORI: begin
                ds_op     = core_pkg::ALU_XOR;
                ds_is_imm = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                ds_op     = core_pkg::ALU_LUI;
                ds_is_imm = 1'b1;
            end
            default: ds_known = 1'b0;
        endcase
    end

    // rt is the target of immediates, rd of register forms
    assign ds_dest_raw = ds_is_imm ? rt : rd;
    assign ds_wen      = ds_known && (ds_dest_raw != '0);
    assign ds_dest     = ds_wen ? ds_dest_raw : '0;

    assign ds_imm_ext = ds_sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    // youngest value of a source, exe first, then writeback, then the file
    always_comb begin
        if (rs == '0) begin
            ds_rs_val = '0;
        end else if (es_fwd_wen && es_dest == rs) begin
            ds_rs_val = es_result;
        end else if (rf_we && rf_waddr == rs) begin
            ds_rs_val = rf_wdata;
        end else begin
            ds_rs_val = rf[rs];
        end
    end

    always_comb begin
        if (rt == '0) begin
            ds_rt_val = '0;
        end else if (es_fwd_wen && es_dest == rt) begin
            ds_rt_val = es_result;
        end else if (rf_we && rf_waddr == rt) begin
            ds_rt_val = rf_wdata;
        end else begin
            ds_rt_val = rf[rt];
        end
    end

    assign ds_src_b = ds_is_imm ? ds_imm_ext : ds_rt_val;

    // register file, entry 0 is never written
    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else begin
            es_valid <= fs_valid;
        end
    end

    // execute payload
    always_ff @(posedge aclk) begin
        if (fs_valid) begin
            es_pc    <= fs_pc;
            es_op    <= ds_op;
            es_src_a <= ds_rs_val;
            es_src_b <= ds_src_b;
            es_shamt <= shamt;
            es_dest  <= ds_dest;
            es_wen   <= ds_wen;
        end
    end

    // a write to r0 never leaves decode
    no_r0_write_a: assert property (@(posedge aclk) disable iff (rst)
        es_valid && es_wen |-> es_dest != '0);

endmodule

// File: src/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                es_valid,
    input  core_pkg::word_t     es_pc,
    input  core_pkg::alu_op_t   es_op,
    input  core_pkg::word_t     es_src_a,
    input  core_pkg::word_t     es_src_b,
    input  logic [4:0]          es_shamt,
    input  core_pkg::reg_addr_t es_dest,
    input  logic                es_wen,
    output logic                es_fwd_wen,
    output core_pkg::word_t     es_result,
    output logic                ws_in_valid,
    output core_pkg::word_t     ws_in_pc,
    output core_pkg::reg_addr_t ws_in_dest,
    output logic                ws_in_wen,
    output core_pkg::word_t     ws_in_result
);

    core_pkg::word_t sum;
    core_pkg::word_t diff;
    logic            lt_signed;
    logic            lt_unsigned;

    // shared adder and compare terms
    assign sum         = es_src_a + es_src_b;
    assign diff        = es_src_a - es_src_b;
    assign lt_signed   = $signed(es_src_a) < $signed(es_src_b);
    assign lt_unsigned = es_src_a < es_src_b;

    always_comb begin
        case (es_op)
            core_pkg::ALU_ADD: begin
                es_result = sum;
            end
            core_pkg::ALU_SUB: begin
                es_result = diff;
            end
            core_pkg::ALU_AND: begin
                es_result = es_src_a & es_src_b;
            end
            core_pkg::ALU_OR: begin
                es_result = es_src_a | es_src_b;
            end
            core_pkg::ALU_XOR: begin
                es_result = es_src_a ^ es_src_b;
            end
            core_pkg::ALU_NOR: begin
                es_result = ~(es_src_a | es_src_b);
            end
            core_pkg::ALU_SLT: begin
                es_result = {31'b0, lt_signed};
            end
            core_pkg::ALU_SLTU: begin
                es_result = {31'b0, lt_unsigned};
            end
            // shifts act on rt, amount from the shamt field
            core_pkg::ALU_SLL: begin
                es_result = es_src_b << es_shamt;
            end
            core_pkg::ALU_SRL: begin
                es_result = es_src_b >> es_shamt;
            end
            core_pkg::ALU_SRA: begin
                es_result = $signed(es_src_b) >>> es_shamt;
            end
            core_pkg::ALU_LUI: begin
                es_result = {es_src_b[15:0], 16'h0000};
            end
            default: begin
                es_result = '0;
            end
        endcase
    end

    // forward only a live write
    assign es_fwd_wen = es_valid & es_wen;

    assign ws_in_valid  = es_valid;
    assign ws_in_pc     = es_pc;
    assign ws_in_dest   = es_dest;
    assign ws_in_wen    = es_wen;
    assign ws_in_result = es_result;

endmodule

// File: src/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                aclk,
    input  logic                rst,
    input  logic                ws_in_valid,
    input  core_pkg::word_t     ws_in_pc,
    input  core_pkg::reg_addr_t ws_in_dest,
    input  logic                ws_in_wen,
    input  core_pkg::word_t     ws_in_result,
    output logic                rf_we,
    output core_pkg::reg_addr_t rf_waddr,
    output core_pkg::word_t     rf_wdata,
    output core_pkg::word_t     debug_wb_pc,
    output core_pkg::rf_wen_t   debug_wb_rf_wen,
    output core_pkg::reg_addr_t debug_wb_rf_wnum,
    output core_pkg::word_t     debug_wb_rf_wdata
);

    logic                ws_valid;
    logic                ws_wen;
    core_pkg::word_t     ws_pc;
    core_pkg::reg_addr_t ws_dest;
    core_pkg::word_t     ws_result;

    always_ff @(posedge aclk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ws_in_valid;
        end
    end

    // pc holds between retirements so the trace shows the last one
    always_ff @(posedge aclk) begin
        if (ws_in_valid) begin
            ws_pc     <= ws_in_pc;
            ws_dest   <= ws_in_dest;
            ws_wen    <= ws_in_wen;
            ws_result <= ws_in_result;
        end
    end

    assign rf_we    = ws_valid & ws_wen;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_wen   = rf_we ? core_pkg::RF_WEN_ALL : '0;
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

    // a trace write needs an instruction handed over from exe one cycle earlier
    trace_wen_a: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen != '0 |-> $past(ws_in_valid));

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::word_t RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
    input  logic                aclk,
    input  logic                rst,
    input  logic                inst_valid,
    input  core_pkg::word_t     inst,
    output core_pkg::word_t     debug_wb_pc,
    output core_pkg::rf_wen_t   debug_wb_rf_wen,
    output core_pkg::reg_addr_t debug_wb_rf_wnum,
    output core_pkg::word_t     debug_wb_rf_wdata
);

    // fetch to decode
    logic                fs_valid;
    core_pkg::word_t     fs_pc;
    core_pkg::word_t     fs_inst;

    // decode to execute
    logic                es_valid;
    core_pkg::word_t     es_pc;
    core_pkg::alu_op_t   es_op;
    core_pkg::word_t     es_src_a;
    core_pkg::word_t     es_src_b;
    logic [4:0]          es_shamt;
    core_pkg::reg_addr_t es_dest;
    logic                es_wen;

    // exe forwarding back into decode
    logic                es_fwd_wen;
    core_pkg::word_t     es_result;

    // execute to writeback
    logic                ws_in_valid;
    core_pkg::word_t     ws_in_pc;
    core_pkg::reg_addr_t ws_in_dest;
    logic                ws_in_wen;
    core_pkg::word_t     ws_in_result;

    // register file write, also the wb forwarding source
    logic                rf_we;
    core_pkg::reg_addr_t rf_waddr;
    core_pkg::word_t     rf_wdata;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .aclk       (aclk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .fs_valid   (fs_valid),
        .fs_pc      (fs_pc),
        .fs_inst    (fs_inst)
    );

    decode_stage decode_i (
        .aclk       (aclk),
        .rst        (rst),
        .fs_valid   (fs_valid),
        .fs_pc      (fs_pc),
        .fs_inst    (fs_inst),
        .es_fwd_wen (es_fwd_wen),
        .es_result  (es_result),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .es_valid   (es_valid),
        .es_pc      (es_pc),
        .es_op      (es_op),
        .es_src_a   (es_src_a),
        .es_src_b   (es_src_b),
        .es_shamt   (es_shamt),
        .es_dest    (es_dest),
        .es_wen     (es_wen)
    );

    exe_stage exe_i (
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .es_op        (es_op),
        .es_src_a     (es_src_a),
        .es_src_b     (es_src_b),
        .es_shamt     (es_shamt),
        .es_dest      (es_dest),
        .es_wen       (es_wen),
        .es_fwd_wen   (es_fwd_wen),
        .es_result    (es_result),
        .ws_in_valid  (ws_in_valid),
        .ws_in_pc     (ws_in_pc),
        .ws_in_dest   (ws_in_dest),
        .ws_in_wen    (ws_in_wen),
        .ws_in_result (ws_in_result)
    );

    wb_stage wb_i (
        .aclk              (aclk),
        .rst               (rst),
        .ws_in_valid       (ws_in_valid),
        .ws_in_pc          (ws_in_pc),
        .ws_in_dest        (ws_in_dest),
        .ws_in_wen         (ws_in_wen),
        .ws_in_result      (ws_in_result),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state of the model core
core_pkg::word_t model_rf [32];
core_pkg::word_t model_pc;

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        model_rf[i] = '0;
    end
    model_pc = core_pkg::DEFAULT_RESET_PC;
endtask

// runs one instruction in program order and returns its trace entry
task automatic execute_inst(
    input  core_pkg::word_t     inst,
    output core_pkg::word_t     pc,
    output core_pkg::rf_wen_t   wen,
    output core_pkg::reg_addr_t wnum,
    output core_pkg::word_t     wdata
);
    logic [5:0]          op;
    logic [5:0]          fn;
    logic [4:0]          sa;
    logic [15:0]         imm;
    core_pkg::reg_addr_t dst;
    core_pkg::word_t     a;
    core_pkg::word_t     b;
    logic signed [31:0]  b_signed;
    core_pkg::word_t     res;
    logic                writes;

    op       = inst[31:26];
    fn       = inst[5:0];
    sa       = inst[10:6];
    imm      = inst[15:0];
    a        = model_rf[inst[25:21]];
    b        = model_rf[inst[20:16]];
    b_signed = b;
    res      = '0;
    writes   = 1'b1;
    if (op == core_pkg::OPC_SPECIAL) begin
        dst = inst[15:11];
        case (fn)
            core_pkg::FN_ADDU: res = a + b;
            core_pkg::FN_SUBU: res = a - b;
            core_pkg::FN_AND:  res = a & b;
            core_pkg::FN_OR:   res = a | b;
            core_pkg::FN_XOR:  res = a ^ b;
            core_pkg::FN_NOR:  res = ~(a | b);
            core_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            core_pkg::FN_SLL:  res = b << sa;
            core_pkg::FN_SRL:  res = b >> sa;
            core_pkg::FN_SRA:  res = b_signed >>> sa;
            default:           writes = 1'b0;
        endcase
    end else begin
        dst = inst[20:16];
        case (op)
            core_pkg::OPC_ADDIU: res = a + {{16{imm[15]}}, imm};
            core_pkg::OPC_ANDI:  res = a & {16'h0000, imm};
            core_pkg::OPC_ORI:   res = a | {16'h0000, imm};
            core_pkg::OPC_XORI:  res = a ^ {16'h0000, imm};
            core_pkg::OPC_LUI:   res = {imm, 16'h0000};
            default:             writes = 1'b0;
        endcase
    end
    // r0 is hardwired to zero
    if (dst == 5'd0) begin
        writes = 1'b0;
    end
    if (writes) begin
        model_rf[dst] = res;
    end
    pc       = model_pc;
    model_pc = model_pc + 32'd4;
    wen      = writes ? core_pkg::RF_WEN_ALL : 4'h0;
    wnum     = writes ? dst : 5'd0;
    wdata    = res;
endtask

`endif

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int NUM_GAPPED     = 300;
    localparam int NUM_CONTINUOUS = 300;
    localparam int DRAIN_LIMIT    = 20;

    logic                aclk;
    logic                rst;
    logic                inst_valid;
    core_pkg::word_t     inst;
    core_pkg::word_t     debug_wb_pc;
    core_pkg::rf_wen_t   debug_wb_rf_wen;
    core_pkg::reg_addr_t debug_wb_rf_wnum;
    core_pkg::word_t     debug_wb_rf_wdata;

    integer              seed;
    int unsigned         cycle;
    logic                checking;
    int                  error_count;
    int                  retire_count;
    core_pkg::word_t     last_pc;

    // expected trace, oldest first
    core_pkg::word_t     exp_pc [$];
    core_pkg::rf_wen_t   exp_wen [$];
    core_pkg::reg_addr_t exp_wnum [$];
    core_pkg::word_t     exp_wdata [$];
    int unsigned         exp_due [$];

    `include "tb_ref_model.svh"

    core_top dut_i (
        .aclk              (aclk),
        .rst               (rst),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    // rising edges seen so far, and whether reset has been released at an edge
    always @(posedge aclk) begin
        cycle    <= cycle + 1;
        checking <= !rst;
    end

    task automatic fail_stop(input string msg);
        error_count++;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input core_pkg::word_t got,
                                input core_pkg::word_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_reg(input string name, input core_pkg::reg_addr_t got,
                               input core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_wen(input string name, input core_pkg::rf_wen_t got,
                               input core_pkg::rf_wen_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // small register range keeps dependencies close together
    task automatic random_inst(output core_pkg::word_t word);
        core_pkg::word_t r;
        core_pkg::word_t r2;
        logic [4:0]      sel;
        logic [5:0]      fn;
        logic [5:0]      opc;

        r   = $random(seed);
        r2  = $random(seed);
        sel = r2[4:0];
        fn  = core_pkg::FN_ADDU;
        opc = core_pkg::OPC_ADDIU;
        if (sel < 22) begin
            case (sel % 11)
                0:       fn = core_pkg::FN_ADDU;
                1:       fn = core_pkg::FN_SUBU;
                2:       fn = core_pkg::FN_AND;
                3:       fn = core_pkg::FN_OR;
                4:       fn = core_pkg::FN_XOR;
                5:       fn = core_pkg::FN_NOR;
                6:       fn = core_pkg::FN_SLT;
                7:       fn = core_pkg::FN_SLTU;
                8:       fn = core_pkg::FN_SLL;
                9:       fn = core_pkg::FN_SRL;
                default: fn = core_pkg::FN_SRA;
            endcase
            word = {core_pkg::OPC_SPECIAL, 2'b00, r[2:0], 2'b00, r[5:3],
                    2'b00, r[8:6], r[13:9], fn};
        end else if (sel < 29) begin
            case ((sel - 22) % 5)
                0:       opc = core_pkg::OPC_ADDIU;
                1:       opc = core_pkg::OPC_ANDI;
                2:       opc = core_pkg::OPC_ORI;
                3:       opc = core_pkg::OPC_XORI;
                default: opc = core_pkg::OPC_LUI;
            endcase
            word = {opc, 2'b00, r[2:0], 2'b00, r[5:3], r[31:16]};
        end else if (sel < 31) begin
            // add, sub, jr and div are outside the kept set
            case (r2[6:5])
                2'd0:    fn = 6'h20;
                2'd1:    fn = 6'h22;
                2'd2:    fn = 6'h08;
                default: fn = 6'h1a;
            endcase
            word = {core_pkg::OPC_SPECIAL, 2'b00, r[2:0], 2'b00, r[5:3],
                    2'b00, r[8:6], r[13:9], fn};
        end else begin
            case (r2[6:5])
                2'd0:    opc = 6'h08;
                2'd1:    opc = 6'h0a;
                2'd2:    opc = 6'h23;
                default: opc = 6'h04;
            endcase
            word = {opc, 2'b00, r[2:0], 2'b00, r[5:3], r[31:16]};
        end
    endtask

    // called at a falling edge, the strobe is sampled at the next rising edge
    task automatic drive_cycle(input logic strobe);
        core_pkg::word_t     word;
        core_pkg::word_t     pc;
        core_pkg::rf_wen_t   wen;
        core_pkg::reg_addr_t wnum;
        core_pkg::word_t     wdata;

        if (strobe) begin
            random_inst(word);
            execute_inst(word, pc, wen, wnum, wdata);
            exp_pc.push_back(pc);
            exp_wen.push_back(wen);
            exp_wnum.push_back(wnum);
            exp_wdata.push_back(wdata);
            exp_due.push_back(cycle + 3);
            inst_valid = 1'b1;
            inst       = word;
        end else begin
            // junk on the bus while idle must be ignored
            inst_valid = 1'b0;
            inst       = $random(seed);
        end
    endtask

    task automatic pop_expected();
        void'(exp_pc.pop_front());
        void'(exp_wen.pop_front());
        void'(exp_wnum.pop_front());
        void'(exp_wdata.pop_front());
        void'(exp_due.pop_front());
    endtask

    // a retirement shows as a new pc or a set write enable
    task automatic check_trace();
        logic retired;

        retired = (debug_wb_pc !== last_pc) || (debug_wb_rf_wen !== 4'h0);
        last_pc = debug_wb_pc;
        if (retired) begin
            if (exp_pc.size() == 0) begin
                fail_stop($sformatf("unexpected retirement of pc %h at cycle %0d",
                                    debug_wb_pc, cycle));
            end else if (exp_due[0] != cycle) begin
                fail_stop($sformatf("pc %h retired at cycle %0d but was due at cycle %0d",
                                    debug_wb_pc, cycle, exp_due[0]));
            end else begin
                compare_word("debug_wb_pc", debug_wb_pc, exp_pc[0]);
                compare_wen("debug_wb_rf_wen", debug_wb_rf_wen, exp_wen[0]);
                if (exp_wen[0] != 4'h0) begin
                    compare_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_wnum[0]);
                    compare_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata[0]);
                end
                pop_expected();
                retire_count++;
            end
        end else if (exp_pc.size() != 0 && exp_due[0] == cycle) begin
            fail_stop($sformatf("instruction at pc %h did not retire at cycle %0d",
                                exp_pc[0], cycle));
        end
    endtask

    always @(negedge aclk) begin
        if (checking) begin
            check_trace();
        end
    end

    initial begin
        int             sent;
        int             waited;
        core_pkg::word_t r;

        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        seed         = 32'h0d2d_f08c;
        cycle        = 0;
        checking     = 1'b0;
        error_count  = 0;
        retire_count = 0;
        last_pc      = 'x;
        reset_model();

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        // strobes with random gaps
        sent = 0;
        while (sent < NUM_GAPPED) begin
            r = $random(seed);
            if (r[1:0] != 2'b00) begin
                drive_cycle(1'b1);
                sent++;
            end else begin
                drive_cycle(1'b0);
            end
            @(negedge aclk);
        end

        // one strobe on every cycle
        for (int n = 0; n < NUM_CONTINUOUS; n++) begin
            drive_cycle(1'b1);
            @(negedge aclk);
        end
        inst_valid = 1'b0;

        waited = 0;
        while (exp_pc.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge aclk);
            waited++;
        end
        if (exp_pc.size() != 0) begin
            fail_stop($sformatf("timeout with %0d instructions not retired, oldest pc %h",
                                exp_pc.size(), exp_pc[0]));
        end

        // a few idle cycles to catch a duplicated retirement
        repeat (4) @(negedge aclk);

        if (error_count == 0 && retire_count == NUM_GAPPED + NUM_CONTINUOUS) begin
            $display("TEST OK");
        end else begin
            $display("retired %0d instructions with %0d errors", retire_count, error_count);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/exe_stage.sv
src/wb_stage.sv
src/core_top.sv
verification/core_tb.sv
